/* verilog.f */
+incdir+common
common/amo_pkg.sv
logic/amo_decoder.sv
amo_bank/amo_alu.sv
amo_bank/amo_bank.sv
logic/amo_dispatch.sv
logic/amo_collect.sv
logic/amo_unit_top.sv
tb/amo_unit_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it and checks the log for a failure
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing -Wno-fatal --top-module amo_unit_tb -f verilog.f -o amo_sim \
  > build.log 2>&1 || { cat build.log; echo "Build failed"; exit 1; }
./obj_dir/amo_sim > sim.log 2>&1
cat sim.log
grep -q "TB FAILED" sim.log && { echo "Simulation failed, see sim.log"; exit 1; }
grep -q "TB PASSED" sim.log && echo "Simulation passed" || {
  echo "Simulation ended without a result line"
  exit 1
}

/* tb/amo_unit_tb.sv */
// Random-stimulus testbench for the atomic memory unit, checks every response against a model
`default_nettype none

module amo_unit_tb;
  import amo_pkg::*;

  localparam int WAIT_LIMIT = 200;
  localparam int MIX_CMDS   = 400;

  logic     clk_i;
  logic     reset_i;
  logic     cmd_valid_i;
  logic     cmd_ready_o;
  amo_cmd_t cmd_i;
  logic     rsp_valid_o;
  logic     rsp_ready_i;
  amo_rsp_t rsp_o;

  // Reference model state
  logic [31:0] model_mem [64];
  logic        resv_valid;
  logic [5:0]  resv_addr;
  amo_rsp_t    exp_q [$];
  string       name_q [$];

  string test_name;
  int    ready_pct;
  int    n_checked;
  logic  cmd_taken;

  amo_unit_top UUT (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .cmd_valid_i (cmd_valid_i),
    .cmd_ready_o (cmd_ready_o),
    .cmd_i       (cmd_i),
    .rsp_valid_o (rsp_valid_o),
    .rsp_ready_i (rsp_ready_i),
    .rsp_o       (rsp_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  ////////////////////////////////////////
  // Failure reporting and compares
  ////////////////////////////////////////

  task automatic abort_run(input string reason);
    $display("Error: %s", reason);
    $display("TB FAILED");
    $fatal(1, "run aborted");
  endtask

  task automatic compare_err(input string tname, input amo_err_e exp, input amo_err_e act);
    if (exp !== act) begin
      $display("Mismatch %s: expected err %s, actual err %s", tname, exp.name(), act.name());
      $display("TB FAILED");
      $fatal(1, "error code check");
    end
  endtask

  task automatic compare_rsp(input string tname, input amo_rsp_t exp, input amo_rsp_t act);
    compare_err(tname, exp.err, act.err);
    if (exp.rd_data !== act.rd_data) begin
      $display("Mismatch %s: expected rd_data %h, actual rd_data %h", tname, exp.rd_data,
               act.rd_data);
      $display("TB FAILED");
      $fatal(1, "response check");
    end
  endtask

  ////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////

  // Stored word of a read-modify-write AMO
  function automatic logic [31:0] model_rmw(input logic [4:0] f, input logic [31:0] a,
                                            input logic [31:0] b);
    case (f)
      AMO_ADD:  return a + b;
      AMO_XOR:  return a ^ b;
      AMO_AND:  return a & b;
      AMO_OR:   return a | b;
      AMO_MIN:  return ($signed(a) < $signed(b)) ? a : b;
      AMO_MAX:  return ($signed(a) > $signed(b)) ? a : b;
      AMO_MINU: return (a < b) ? a : b;
      AMO_MAXU: return (a > b) ? a : b;
      default:  return b;
    endcase
  endfunction

  // Applies one accepted command and queues its expected response
  task automatic model_accept(input amo_cmd_t cmd);
    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [4:0] funct5;
    logic [5:0] waddr;
    logic       known;
    logic       is_sc;
    amo_rsp_t   exp;
    opcode = cmd.instr.raw[6:0];
    funct3 = cmd.instr.raw[14:12];
    funct5 = cmd.instr.raw[31:27];
    waddr  = cmd.rs1_data[7:2];
    known  = funct5 inside {AMO_LR, AMO_SC, AMO_SWAP, AMO_ADD, AMO_XOR, AMO_AND, AMO_OR,
                            AMO_MIN, AMO_MAX, AMO_MINU, AMO_MAXU};
    // Any SC encoding drops the reservation, even a faulting one
    is_sc  = (opcode == 7'b0101111) && (funct5 == 5'b00011);
    exp.rd_data = 32'd0;
    if ((opcode != 7'b0101111) || (funct3 != 3'b010) || !known) begin
      exp.err = ERR_ILLEGAL;
      if (is_sc) begin
        resv_valid = 1'b0;
      end
    end else if (cmd.rs1_data[1:0] != 2'b00) begin
      exp.err = ERR_MISALIGNED;
      if (is_sc) begin
        resv_valid = 1'b0;
      end
    end else begin
      exp.err = ERR_NONE;
      case (funct5)
        AMO_LR: begin
          exp.rd_data = model_mem[waddr];
          resv_valid  = 1'b1;
          resv_addr   = waddr;
        end
        AMO_SC: begin
          if (resv_valid && (resv_addr == waddr)) begin
            model_mem[waddr] = cmd.rs2_data;
          end else begin
            exp.rd_data = 32'd1;
          end
          resv_valid = 1'b0;
        end
        default: begin
          exp.rd_data      = model_mem[waddr];
          model_mem[waddr] = model_rmw(funct5, model_mem[waddr], cmd.rs2_data);
          if (resv_valid && (resv_addr == waddr)) begin
            resv_valid = 1'b0;
          end
        end
      endcase
    end
    exp_q.push_back(exp);
    name_q.push_back(test_name);
  endtask

  ////////////////////////////////////////
  // Cycle driver
  ////////////////////////////////////////

  // Observe handshakes at the falling edge, drive at the rising edge
  task automatic tick();
    amo_rsp_t exp;
    string    tname;
    @(negedge clk_i);
    if (rsp_valid_o && rsp_ready_i) begin
      if (exp_q.size() == 0) begin
        abort_run("response arrived with no command outstanding");
      end else begin
        exp   = exp_q.pop_front();
        tname = name_q.pop_front();
        compare_rsp(tname, exp, rsp_o);
        n_checked++;
      end
    end
    if (cmd_valid_i && cmd_ready_o) begin
      model_accept(cmd_i);
      cmd_taken = 1'b1;
    end
    @(posedge clk_i);
    rsp_ready_i <= (($urandom % 100) < ready_pct);
  endtask

  // Holds the command valid until it is taken
  task automatic issue(input amo_instr_u instr, input logic [31:0] rs1, input logic [31:0] rs2);
    amo_cmd_t cmd;
    int       waited;
    cmd.instr    = instr;
    cmd.rs1_data = rs1;
    cmd.rs2_data = rs2;
    cmd_valid_i <= 1'b1;
    cmd_i       <= cmd;
    cmd_taken = 1'b0;
    waited    = 0;
    while (!cmd_taken) begin
      if (waited == WAIT_LIMIT) begin
        abort_run("timed out waiting for cmd_ready_o");
      end else begin
        tick();
        waited++;
      end
    end
  endtask

  task automatic drain();
    int waited;
    cmd_valid_i <= 1'b0;
    waited = 0;
    while (exp_q.size() != 0) begin
      if (waited == WAIT_LIMIT * 4) begin
        abort_run("timed out waiting for outstanding responses");
      end else begin
        tick();
        waited++;
      end
    end
  endtask

  ////////////////////////////////////////
  // Stimulus helpers
  ////////////////////////////////////////

  // Register fields and aq/rl stay random
  function automatic amo_instr_u make_instr(input logic [4:0] funct5, input logic [2:0] funct3,
                                            input logic [6:0] opcode);
    amo_instr_u instr;
    instr.raw      = $urandom;
    instr.r.funct5 = funct5;
    instr.r.funct3 = funct3;
    instr.r.opcode = opcode;
    return instr;
  endfunction

  task automatic issue_amo(input logic [4:0] funct5, input logic [31:0] rs1,
                           input logic [31:0] rs2);
    issue(make_instr(funct5, 3'b010, 7'b0101111), rs1, rs2);
  endtask

  function automatic logic [4:0] pick_rmw_func();
    case ($urandom % 9)
      0:       return AMO_SWAP;
      1:       return AMO_ADD;
      2:       return AMO_XOR;
      3:       return AMO_AND;
      4:       return AMO_OR;
      5:       return AMO_MIN;
      6:       return AMO_MAX;
      7:       return AMO_MINU;
      default: return AMO_MAXU;
    endcase
  endfunction

  // Sign and range boundaries mixed with plain random words
  function automatic logic [31:0] pick_operand();
    case ($urandom % 6)
      0:       return 32'h0000_0000;
      1:       return 32'h0000_0001;
      2:       return 32'h7fff_ffff;
      3:       return 32'h8000_0000;
      4:       return 32'hffff_ffff;
      default: return $urandom;
    endcase
  endfunction

  // Mix of legal AMOs, LR/SC and every kind of faulting word
  function automatic amo_instr_u pick_instr();
    case ($urandom % 10)
      0:       return make_instr(5'($urandom), 3'b010, 7'b0101111);
      1:       return make_instr(pick_rmw_func(), 3'($urandom), 7'b0101111);
      2:       return make_instr(AMO_ADD, 3'b010, 7'($urandom));
      3:       return make_instr(AMO_LR, 3'b010, 7'b0101111);
      4:       return make_instr(AMO_SC, 3'b010, 7'b0101111);
      default: return make_instr(pick_rmw_func(), 3'b010, 7'b0101111);
    endcase
  endfunction

  ////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////

  initial begin
    logic [31:0] addr;
    logic [31:0] rs1;
    void'($urandom(32'h81dff75e));
    reset_i     = 1'b1;
    cmd_valid_i = 1'b0;
    cmd_i       = '0;
    rsp_ready_i = 1'b0;
    resv_valid  = 1'b0;
    resv_addr   = '0;
    ready_pct   = 90;
    n_checked   = 0;
    cmd_taken   = 1'b0;
    test_name   = "reset";
    for (int i = 0; i < 64; i++) begin
      model_mem[i] = 32'd0;
    end
    repeat (8) @(posedge clk_i);
    reset_i <= 1'b0;
    @(negedge clk_i);
    if (rsp_valid_o !== 1'b0) begin
      abort_run("rsp_valid_o is high after reset");
    end
    @(posedge clk_i);

    // Few words so functions act on each other's results
    test_name = "amo_arith";
    for (int i = 0; i < 200; i++) begin
      addr = ($urandom & 32'hffff_ff00) | (($urandom % 8) << 2);
      issue_amo(pick_rmw_func(), addr, pick_operand());
      issue_amo(AMO_LR, addr, 32'd0);
    end
    drain();

    test_name = "lr_sc";
    addr = 32'h0000_0040;
    issue_amo(AMO_SWAP, addr, 32'h1234_5678);
    issue_amo(AMO_LR, addr, 32'd0);
    issue_amo(AMO_SC, addr, 32'hcafe_0001);
    issue_amo(AMO_SC, addr, 32'hcafe_0002);
    issue_amo(AMO_LR, addr, 32'd0);
    // Store to the reserved word
    issue_amo(AMO_ADD, addr, 32'd5);
    issue_amo(AMO_SC, addr, 32'hcafe_0003);
    issue_amo(AMO_LR, addr, 32'd0);
    // SC elsewhere consumes the reservation
    issue_amo(AMO_SC, addr + 32'd4, 32'hcafe_0004);
    issue_amo(AMO_SC, addr, 32'hcafe_0005);
    issue_amo(AMO_LR, addr, 32'd0);
    drain();

    test_name = "illegal";
    issue(make_instr(AMO_ADD, 3'b010, 7'b0110011), addr, 32'd1);
    issue(make_instr(AMO_ADD, 3'b011, 7'b0101111), addr, 32'd1);
    issue(make_instr(5'b00101, 3'b010, 7'b0101111), addr, 32'd1);
    // Doubleword SC faults and still drops the reservation
    issue(make_instr(AMO_SC, 3'b011, 7'b0101111), addr, 32'd1);
    issue_amo(AMO_SC, addr, 32'h0000_0099);
    issue_amo(AMO_LR, addr, 32'd0);
    drain();

    test_name = "misaligned";
    for (int i = 1; i < 4; i++) begin
      issue_amo(AMO_ADD, addr | i, 32'd16);
      issue_amo(AMO_SWAP, (addr + 32'd8) | i, 32'hdead_beef);
    end
    issue_amo(AMO_LR, addr, 32'd0);
    issue_amo(AMO_LR, addr + 32'd8, 32'd0);
    drain();

    // Heavy back-pressure keeps the banks and the order queue full
    test_name = "ordering";
    for (int i = 0; i < MIX_CMDS; i++) begin
      ready_pct = (i < MIX_CMDS / 2) ? 40 : 15;
      rs1 = $urandom;
      if (($urandom % 5) != 0) begin
        rs1[1:0] = 2'b00;
      end
      issue(pick_instr(), rs1, pick_operand());
    end
    drain();

    test_name = "addr_wrap";
    ready_pct = 90;
    for (int i = 0; i < 16; i++) begin
      addr = ($urandom % 64) << 2;
      issue_amo(AMO_SWAP, addr | ($urandom << 8), $urandom);
      issue_amo(AMO_LR, addr | ($urandom << 8), 32'd0);
    end
    drain();

    // Empty unit offers no response and has room for a new command
    @(negedge clk_i);
    if ((rsp_valid_o === 1'b0) && (cmd_ready_o === 1'b1)) begin
      $display("TB PASSED");
      $finish;
    end else begin
      $display("Error: unit not idle after all %0d responses were checked", n_checked);
      $display("TB FAILED");
      $fatal(1, "idle check");
    end
  end

endmodule

`default_nettype wire

/* logic/amo_unit_top.sv */
// Atomic memory unit top, wires the dispatcher, the bank array and the collector
`default_nettype none

`include "amo_defs.svh"

module amo_unit_top (
  input  logic              clk_i,
  input  logic              reset_i,
  input  logic              cmd_valid_i,
  output logic              cmd_ready_o,
  input  amo_pkg::amo_cmd_t cmd_i,
  output logic              rsp_valid_o,
  input  logic              rsp_ready_i,
  output amo_pkg::amo_rsp_t rsp_o
);
  import amo_pkg::*;

  logic [`AMO_NUM_BANKS-1:0]          bank_req_valid;
  logic [`AMO_NUM_BANKS-1:0]          bank_req_ready;
  amo_bank_req_t [`AMO_NUM_BANKS-1:0] bank_req;
  logic [`AMO_NUM_BANKS-1:0]          bank_rsp_valid;
  logic [`AMO_NUM_BANKS-1:0]          bank_rsp_ready;
  amo_bank_rsp_t [`AMO_NUM_BANKS-1:0] bank_rsp;
  logic                               order_push;
  logic                               order_full;
  amo_order_t                         order;

  ////////////////////////////////////////
  // Front end
  ////////////////////////////////////////

  amo_dispatch u_dispatch (
    .clk_i            (clk_i),
    .reset_i          (reset_i),
    .cmd_valid_i      (cmd_valid_i),
    .cmd_ready_o      (cmd_ready_o),
    .cmd_i            (cmd_i),
    .bank_req_valid_o (bank_req_valid),
    .bank_req_ready_i (bank_req_ready),
    .bank_req_o       (bank_req),
    .order_push_o     (order_push),
    .order_full_i     (order_full),
    .order_o          (order)
  );

  // One bank per address bits 3:2 value
  for (genvar k = 0; k < `AMO_NUM_BANKS; k++) begin : g_bank
    amo_bank u_bank (
      .clk_i       (clk_i),
      .reset_i     (reset_i),
      .req_valid_i (bank_req_valid[k]),
      .req_ready_o (bank_req_ready[k]),
      .req_i       (bank_req[k]),
      .rsp_valid_o (bank_rsp_valid[k]),
      .rsp_ready_i (bank_rsp_ready[k]),
      .rsp_o       (bank_rsp[k])
    );
  end

  ////////////////////////////////////////
  // In-order return
  ////////////////////////////////////////

  amo_collect u_collect (
    .clk_i            (clk_i),
    .reset_i          (reset_i),
    .order_push_i     (order_push),
    .order_full_o     (order_full),
    .order_i          (order),
    .bank_rsp_valid_i (bank_rsp_valid),
    .bank_rsp_ready_o (bank_rsp_ready),
    .bank_rsp_i       (bank_rsp),
    .rsp_valid_o      (rsp_valid_o),
    .rsp_ready_i      (rsp_ready_i),
    .rsp_o            (rsp_o)
  );

endmodule

`default_nettype wire

/* logic/amo_collect.sv */
// Order queue and response drain, returns bank results and errors in issue order
`default_nettype none

`include "amo_defs.svh"

module amo_collect (
  input  logic                                        clk_i,
  input  logic                                        reset_i,
  input  logic                                        order_push_i,
  output logic                                        order_full_o,
  input  amo_pkg::amo_order_t                         order_i,
  input  logic [`AMO_NUM_BANKS-1:0]                   bank_rsp_valid_i,
  output logic [`AMO_NUM_BANKS-1:0]                   bank_rsp_ready_o,
  input  amo_pkg::amo_bank_rsp_t [`AMO_NUM_BANKS-1:0] bank_rsp_i,
  output logic                                        rsp_valid_o,
  input  logic                                        rsp_ready_i,
  output amo_pkg::amo_rsp_t                           rsp_o
);
  import amo_pkg::*;

  localparam int unsigned PTR_W = $clog2(`AMO_ORDER_DEPTH);
  localparam int unsigned CNT_W = $clog2(`AMO_ORDER_DEPTH + 1);

  amo_order_t       queue [`AMO_ORDER_DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  amo_order_t       head;
  logic             head_err;
  logic             pop;

  assign order_full_o = (count == CNT_W'(`AMO_ORDER_DEPTH));
  assign head         = queue[rd_ptr];
  assign head_err     = (head.err != ERR_NONE);

  ////////////////////////////////////////
  // Response offer from the head entry
  ////////////////////////////////////////

  // Errors go out at once, results wait for their bank
  assign rsp_valid_o   = (count != '0) && (head_err || bank_rsp_valid_i[head.bank]);
  assign rsp_o.err     = head.err;
  assign rsp_o.rd_data = head_err ? 32'd0 : bank_rsp_i[head.bank].rdata;
  assign pop           = rsp_valid_o && rsp_ready_i;

  always_comb begin
    for (int k = 0; k < `AMO_NUM_BANKS; k++) begin
      // Release only the slot the head names
      bank_rsp_ready_o[k] = pop && !head_err && (head.bank == BANK_IDX_W'(k));
    end
  end

  ////////////////////////////////////////
  // Circular queue
  ////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (order_push_i) begin
        wr_ptr <= (wr_ptr == PTR_W'(`AMO_ORDER_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == PTR_W'(`AMO_ORDER_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      // Push and pop together leave the count alone
      if (order_push_i && !pop) begin
        count <= count + 1'b1;
      end else if (pop && !order_push_i) begin
        count <= count - 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (order_push_i) begin
      queue[wr_ptr] <= order_i;
    end
  end

endmodule

`default_nettype wire

/* logic/amo_dispatch.sv */
// Command front end, decodes and checks each command, keeps the reservation and feeds banks
`default_nettype none

`include "amo_defs.svh"

module amo_dispatch (
  input  logic                                         clk_i,
  input  logic                                         reset_i,
  input  logic                                         cmd_valid_i,
  output logic                                         cmd_ready_o,
  input  amo_pkg::amo_cmd_t                            cmd_i,
  output logic [`AMO_NUM_BANKS-1:0]                    bank_req_valid_o,
  input  logic [`AMO_NUM_BANKS-1:0]                    bank_req_ready_i,
  output amo_pkg::amo_bank_req_t [`AMO_NUM_BANKS-1:0]  bank_req_o,
  output logic                                         order_push_o,
  input  logic                                         order_full_i,
  output amo_pkg::amo_order_t                          order_o
);
  import amo_pkg::*;

  amo_ctrl_t              ctrl;
  logic [31:0]            addr;
  logic [BANK_IDX_W-1:0]  bank_idx;
  logic [ROW_W-1:0]       row;
  logic [WORD_ADDR_W-1:0] word_addr;
  amo_func_e              func;
  amo_err_e               err;
  logic                   is_sc_word;
  logic                   is_lr;
  logic                   accept;
  logic                   resv_valid;
  logic [WORD_ADDR_W-1:0] resv_addr;
  logic                   resv_hit;
  amo_bank_req_t          req;

  amo_decoder u_decoder (
    .instr_i (cmd_i.instr),
    .ctrl_o  (ctrl)
  );

  ////////////////////////////////////////
  // Address split and error check
  ////////////////////////////////////////

  assign addr      = cmd_i.rs1_data;
  // Bank from bits 3:2, row above it, upper bits wrap
  assign bank_idx  = addr[BANK_IDX_W+1:2];
  assign row       = addr[WORD_ADDR_W+1:BANK_IDX_W+2];
  assign word_addr = addr[WORD_ADDR_W+1:2];
  assign func      = amo_func_e'(ctrl.data_atop[4:0]);

  always_comb begin
    if (!ctrl.match || ctrl.illegal_insn) begin
      err = ERR_ILLEGAL;
    end else if (addr[1:0] != 2'b00) begin
      err = ERR_MISALIGNED;
    end else begin
      err = ERR_NONE;
    end
  end

  // Any SC encoding, legal or not, drops the reservation
  assign is_sc_word = (cmd_i.instr.r.opcode == OPCODE_AMO) && (cmd_i.instr.r.funct5 == AMO_SC);
  assign is_lr      = (err == ERR_NONE) && (func == AMO_LR);

  ////////////////////////////////////////
  // Handshake
  ////////////////////////////////////////

  // Errors need only queue room, real requests also need their bank
  assign cmd_ready_o  = !order_full_i && ((err != ERR_NONE) || bank_req_ready_i[bank_idx]);
  assign accept       = cmd_valid_i && cmd_ready_o;
  assign order_push_o = accept;
  assign order_o      = '{bank: bank_idx, err: err};

  ////////////////////////////////////////
  // Reservation
  ////////////////////////////////////////

  assign resv_hit = resv_valid && (resv_addr == word_addr);

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      resv_valid <= 1'b0;
    end else if (accept) begin
      if (is_sc_word) begin
        resv_valid <= 1'b0;
      end else if (is_lr) begin
        resv_valid <= 1'b1;
      end else if ((err == ERR_NONE) && ctrl.data_we && resv_hit) begin
        // Store to the reserved word breaks it
        resv_valid <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept && is_lr) begin
      resv_addr <= word_addr;
    end
  end

  ////////////////////////////////////////
  // Bank request fan-out
  ////////////////////////////////////////

  // sc_ok sampled before this command updates the reservation
  assign req = '{func: func, row: row, wdata: cmd_i.rs2_data, sc_ok: resv_hit};

  always_comb begin
    for (int k = 0; k < `AMO_NUM_BANKS; k++) begin
      // Payload shared, only the addressed bank sees valid
      bank_req_o[k]       = req;
      bank_req_valid_o[k] = accept && (err == ERR_NONE) && (bank_idx == BANK_IDX_W'(k));
    end
  end

endmodule

`default_nettype wire

/* amo_bank/amo_bank.sv */
// One memory bank with a single result slot, performs each atomic in one clock edge
`default_nettype none

`include "amo_defs.svh"

module amo_bank (
  input  logic                   clk_i,
  input  logic                   reset_i,
  input  logic                   req_valid_i,
  output logic                   req_ready_o,
  input  amo_pkg::amo_bank_req_t req_i,
  output logic                   rsp_valid_o,
  input  logic                   rsp_ready_i,
  output amo_pkg::amo_bank_rsp_t rsp_o
);
  import amo_pkg::*;

  logic [31:0] mem [`AMO_BANK_DEPTH];
  logic [31:0] old_word;
  logic [31:0] alu_word;
  logic [31:0] result;
  logic        we;
  logic        accept;
  logic        slot_valid;
  logic [31:0] slot_data;

  // Slot free, or emptied this cycle
  assign req_ready_o = !slot_valid || rsp_ready_i;
  assign accept      = req_valid_i && req_ready_o;
  assign old_word    = mem[req_i.row];

  amo_alu u_alu (
    .func_i    (req_i.func),
    .old_i     (old_word),
    .operand_i (req_i.wdata),
    .new_o     (alu_word)
  );

  ////////////////////////////////////////
  // Result and write enable per function
  ////////////////////////////////////////

  always_comb begin
    case (req_i.func)
      AMO_LR: begin
        result = old_word;
        we     = 1'b0;
      end
      AMO_SC: begin
        // 0 on success, 1 on failure
        result = {31'd0, !req_i.sc_ok};
        we     = req_i.sc_ok;
      end
      default: begin
        result = old_word;
        we     = 1'b1;
      end
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      for (int i = 0; i < `AMO_BANK_DEPTH; i++) begin
        mem[i] <= '0;
      end
    end else if (accept && we) begin
      // ALU passes wdata for SC
      mem[req_i.row] <= alu_word;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      slot_valid <= 1'b0;
    end else if (accept) begin
      slot_valid <= 1'b1;
    end else if (rsp_ready_i) begin
      slot_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      slot_data <= result;
    end
  end

  assign rsp_valid_o = slot_valid;
  assign rsp_o       = '{rdata: slot_data};

endmodule

`default_nettype wire

/* amo_bank/amo_alu.sv */
// Read-modify-write arithmetic, gives the word a writing AMO stores back to the bank
`default_nettype none

module amo_alu (
  input  amo_pkg::amo_func_e func_i,
  input  logic [31:0]        old_i,
  input  logic [31:0]        operand_i,
  output logic [31:0]        new_o
);
  import amo_pkg::*;

  logic signed_lt;
  logic unsigned_lt;

  // Comparisons shared by the min and max variants
  assign signed_lt   = $signed(old_i) < $signed(operand_i);
  assign unsigned_lt = old_i < operand_i;

  always_comb begin
    case (func_i)
      AMO_ADD: new_o = old_i + operand_i;
      AMO_XOR: new_o = old_i ^ operand_i;
      AMO_AND: new_o = old_i & operand_i;
      AMO_OR:  new_o = old_i | operand_i;
      // Keep the smaller, signed
      AMO_MIN: new_o = signed_lt ? old_i : operand_i;
      // Keep the larger, signed
      AMO_MAX: new_o = signed_lt ? operand_i : old_i;
      // Unsigned pair
      AMO_MINU: new_o = unsigned_lt ? old_i : operand_i;
      AMO_MAXU: new_o = unsigned_lt ? operand_i : old_i;
      // SWAP, and SC store data, pass the operand
      default: new_o = operand_i;
    endcase
  end

endmodule

`default_nettype wire

/* logic/amo_decoder.sv */
// RV32A decoder, turns one instruction word into the AMO control struct for dispatch
`default_nettype none

module amo_decoder (
  input  amo_pkg::amo_instr_u instr_i,
  output amo_pkg::amo_ctrl_t  ctrl_o
);
  import amo_pkg::*;

  logic is_amo_opcode;
  logic is_word;

  // Raw view for opcode and width test
  assign is_amo_opcode = (instr_i.raw[6:0] == OPCODE_AMO);
  // funct3 010 selects word size, doubleword not supported
  assign is_word       = (instr_i.raw[14:12] == 3'b010);

  ////////////////////////////////////////
  // Control generation
  ////////////////////////////////////////

  always_comb begin
    // Anything outside the AMO opcode keeps idle control
    ctrl_o = amo_ctrl_idle;

    if (is_amo_opcode) begin
      if (is_word) begin
        ctrl_o.match     = 1'b1;
        // Every AMO writes rd
        ctrl_o.rf_we     = 1'b1;
        // Atomic function carried through with its valid bit
        ctrl_o.data_atop = {1'b1, instr_i.r.funct5};

        // Field view for funct5 decode
        case (instr_i.r.funct5)
          AMO_LR: begin
            // Load reserved only reads
            ctrl_o.data_we = 1'b0;
          end
          AMO_SC,
          AMO_SWAP,
          AMO_ADD,
          AMO_XOR,
          AMO_AND,
          AMO_OR,
          AMO_MIN,
          AMO_MAX,
          AMO_MINU,
          AMO_MAXU: begin
            // SC writes only on success, resolved later in the bank
            ctrl_o.data_we = 1'b1;
          end
          default: begin
            // Reserved funct5
            ctrl_o.illegal_insn = 1'b1;
          end
        endcase
      end else begin
        // AMO opcode with a width other than word
        ctrl_o.illegal_insn = 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

/* common/amo_pkg.sv */
// Shared types and encodings for the atomic memory unit, imported by every RTL block
`default_nettype none

`include "amo_defs.svh"

package amo_pkg;

  ////////////////////////////////////////
  // Widths derived from the geometry
  ////////////////////////////////////////

  localparam int unsigned BANK_IDX_W  = $clog2(`AMO_NUM_BANKS);
  localparam int unsigned ROW_W       = $clog2(`AMO_BANK_DEPTH);
  // Word address inside the memory, row above bank
  localparam int unsigned WORD_ADDR_W = BANK_IDX_W + ROW_W;

  // Major opcode shared by all A-extension words
  localparam logic [6:0] OPCODE_AMO = 7'h2f;

  // funct5 encodings of the RV32A functions
  typedef enum logic [4:0] {
    AMO_LR   = 5'b00010,
    AMO_SC   = 5'b00011,
    AMO_SWAP = 5'b00001,
    AMO_ADD  = 5'b00000,
    AMO_XOR  = 5'b00100,
    AMO_AND  = 5'b01100,
    AMO_OR   = 5'b01000,
    AMO_MIN  = 5'b10000,
    AMO_MAX  = 5'b10100,
    AMO_MINU = 5'b11000,
    AMO_MAXU = 5'b11100
  } amo_func_e;

  ////////////////////////////////////////
  // Instruction word, two views
  ////////////////////////////////////////

  // R-type layout as used by AMOs
  typedef struct packed {
    logic [4:0] funct5;
    logic       aq;
    logic       rl;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } amo_rtype_t;

  typedef union packed {
    logic [31:0] raw;
    amo_rtype_t  r;
  } amo_instr_u;

  // One command, instruction plus operand values
  typedef struct packed {
    amo_instr_u  instr;
    logic [31:0] rs1_data;
    logic [31:0] rs2_data;
  } amo_cmd_t;

  // Decoder control, data_atop is valid bit plus funct5
  typedef struct packed {
    logic       match;
    logic       illegal_insn;
    logic       data_we;
    logic [5:0] data_atop;
    logic       rf_we;
  } amo_ctrl_t;

  localparam amo_ctrl_t amo_ctrl_idle = '0;

  ////////////////////////////////////////
  // Internal and response transfers
  ////////////////////////////////////////

  typedef struct packed {
    amo_func_e        func;
    logic [ROW_W-1:0] row;
    logic [31:0]      wdata;
    logic             sc_ok;
  } amo_bank_req_t;

  typedef struct packed {
    logic [31:0] rdata;
  } amo_bank_rsp_t;

  typedef enum logic [1:0] {
    ERR_NONE       = 2'd0,
    ERR_ILLEGAL    = 2'd1,
    ERR_MISALIGNED = 2'd2
  } amo_err_e;

  // Issue order entry, which bank holds the result or why none exists
  typedef struct packed {
    logic [BANK_IDX_W-1:0] bank;
    amo_err_e              err;
  } amo_order_t;

  typedef struct packed {
    logic [31:0] rd_data;
    amo_err_e    err;
  } amo_rsp_t;

endpackage

`default_nettype wire

/* common/amo_defs.svh */
// Sizing macros for the atomic memory unit, included by the package and the RTL
`ifndef AMO_DEFS_SVH
`define AMO_DEFS_SVH

////////////////////////////////////////
// Memory geometry
////////////////////////////////////////

// Banks, selected by address bits 3:2
`define AMO_NUM_BANKS 4

// Words per bank, row from address bits 7:4
`define AMO_BANK_DEPTH 16

// Order queue entries, bounds commands in flight
`define AMO_ORDER_DEPTH 4

`endif
